// ==== list.f ====
+incdir+verification
verilog/adam_glue_pkg.sv
verilog/ctrl_port_if.sv
verilog/clock_reset_gen.sv
verilog/keypad_encoder.sv
verilog/controller_ports.sv
verilog/image_channel_mux.sv
verilog/av_output_stage.sv
verilog/adam_io_glue.sv
verification/tb_adam_io_glue.sv

// ==== verification/tb_adam_io_glue_checks.svh ====
// Compare tasks, wait helpers and counters
// Included inside the testbench module after the DUT signals are declared
`ifndef TB_ADAM_IO_GLUE_CHECKS_SVH
`define TB_ADAM_IO_GLUE_CHECKS_SVH

int check_count = 0;
int error_count = 0;
int test_count  = 0;
int test_errors_start = 0;
bit timed_out = 1'b0;

task automatic check_code(input string name, input cv_code_t got, input cv_code_t exp);
        check_count++;
        if (got !== exp) begin
                error_count++;
                $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
                error_count++;
                $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
endtask

task automatic check_lba(input string name, input lba_t got, input lba_t exp);
        check_count++;
        if (got !== exp) begin
                error_count++;
                $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
endtask

task automatic check_byte(input string name, input sd_byte_t got, input sd_byte_t exp);
        check_count++;
        if (got !== exp) begin
                error_count++;
                $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
endtask

task automatic check_dac(input string name, input dac_t got, input dac_t exp);
        check_count++;
        if (got !== exp) begin
                error_count++;
                $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
        end
endtask

// Returns on the falling edge where ce_fast_o is high
task automatic wait_ce_fast(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk_sys);
        while (ce_fast_o !== 1'b1 && n < max_cycles) begin
                @(negedge clk_sys);
                n++;
        end
        if (ce_fast_o !== 1'b1) begin
                timed_out = 1'b1;
                error_count++;
                $display("Timeout: ce_fast_o did not pulse within %0d cycles", max_cycles);
        end
endtask

task automatic wait_core_running(input int max_cycles);
        int n;
        n = 0;
        @(negedge clk_sys);
        while (core_rst_n_o !== 1'b1 && n < max_cycles) begin
                @(negedge clk_sys);
                n++;
        end
        if (core_rst_n_o !== 1'b1) begin
                timed_out = 1'b1;
                error_count++;
                $display("Timeout: core_rst_n_o stayed low for %0d cycles", max_cycles);
        end
endtask

task automatic begin_test();
        test_errors_start = error_count;
        test_count++;
endtask

task automatic end_test(input string name);
        if (error_count == test_errors_start) begin
                $display("Test %s: ok", name);
        end else begin
                $display("Test %s: %0d mismatches", name, error_count - test_errors_start);
        end
endtask

`endif

// ==== verification/tb_adam_io_glue.sv ====
// Testbench for the IO glue with default parameters, so four image requesters
// Inputs change on the rising edge and outputs are sampled on the falling edge
module tb_adam_io_glue import adam_glue_pkg::*; ();

        typedef struct packed {
                joy_t     joy;
                cv_code_t code;
                logic     fire_n;
        } kp_row_t;

        typedef struct packed {
                logic [3:0] rd;
                logic [3:0] wr;
                logic       ack;
        } img_row_t;

        logic clk_sys, rst_n_i, pll_locked_i, reset_req_i, button_reset_i, download_i;
        logic joy_swap_i, host_ack_i, hsync_n_i, vsync_n_i;
        joy_t joy0_i, joy1_i;
        logic [1:0] sel_keypad_n_i, sel_joy_n_i, ctrl_fire_n_o;
        logic [3:0] img_rd_i, img_wr_i, img_ack_o;
        lba_t [3:0] img_lba_i;
        sd_byte_t [3:0] img_din_i;
        audio_t audio_i;
        logic ce_fast_o, ce_pix_o, core_rst_n_o, activity_o, hs_o, vs_o;
        cv_code_t ctrl_code0_o, ctrl_code1_o;
        lba_t host_lba_o;
        sd_byte_t host_din_o;
        dac_t dac_l_o, dac_r_o;
        integer seed = 65541;

        `include "tb_adam_io_glue_checks.svh"

        // Single and multiple presses on player 0 with only the keypad select low
        localparam kp_row_t kp_table [0:7] = '{
                '{32'h0000_0100, 4'b0011, 1'b1}, '{32'h0000_8800, 4'b0110, 1'b1},
                '{32'h0000_0040, 4'b1010, 1'b1}, '{32'h0002_0080, 4'b1011, 1'b1},
                '{32'h0004_0000, 4'b0100, 1'b1}, '{32'h0008_0020, 4'b0010, 1'b0},
                '{32'h0000_001f, 4'b1111, 1'b1}, '{32'h0004_2040, 4'b1001, 1'b1}
        };

        // Row bits are swap, sel_keypad_n and sel_joy_n
        localparam logic [4:0] mode_table [0:7] = '{
                5'b0_11_00, 5'b0_00_11, 5'b0_00_00, 5'b0_11_11,
                5'b1_10_01, 5'b1_01_10, 5'b1_00_00, 5'b0_01_10
        };

        localparam img_row_t img_table [0:7] = '{
                '{4'b0001, 4'b0000, 1'b1}, '{4'b0000, 4'b0100, 1'b1},
                '{4'b0010, 4'b1000, 1'b0}, '{4'b0000, 4'b0000, 1'b1},
                '{4'b0101, 4'b0000, 1'b1}, '{4'b0000, 4'b0000, 1'b0},
                '{4'b0000, 4'b0010, 1'b1}, '{4'b1000, 4'b0001, 1'b1}
        };

        // Hsync_n and vsync_n per row
        localparam logic [1:0] sync_table [0:11] = '{
                2'b11, 2'b01, 2'b00, 2'b00, 2'b10, 2'b11,
                2'b00, 2'b01, 2'b11, 2'b10, 2'b00, 2'b11
        };

        // Port codes for keypad index 0 to 13
        localparam cv_code_t key_codes [0:13] = '{
                4'b0011, 4'b1110, 4'b1101, 4'b0110, 4'b0001, 4'b1001, 4'b0111,
                4'b1100, 4'b1000, 4'b1011, 4'b1010, 4'b0101, 4'b0100, 4'b0010
        };

        adam_io_glue u_adam_io_glue (.*);

        initial begin
                clk_sys = 1'b0;
                forever #50 clk_sys = ~clk_sys;
        end

        // Expected {code, fire_n} of one port from the host joystick word
        function automatic logic [4:0] port_model(input joy_t joy, input logic selk_n,
                                                  input logic selj_n);
                logic [13:0] keys;
                cv_code_t    kc;
                cv_code_t    code;
                logic        fire_n;
                keys = {joy[19], joy[18], joy[7], joy[6], joy[17:8]};
                kc = 4'b1111;
                for (int i = 13; i >= 0; i--) begin
                        if (keys[i]) kc = key_codes[i];
                end
                code = 4'b1111;
                fire_n = 1'b1;
                if (!selk_n) begin
                        code = code & kc;
                        fire_n = fire_n & ~joy[5];
                end
                if (!selj_n) begin
                        code = code & ~{joy[3], joy[2], joy[1], joy[0]};
                        fire_n = fire_n & ~joy[4];
                end
                return {code, fire_n};
        endfunction

        // ======================================================================
        // Test sequence
        // ======================================================================
        initial begin
                logic [4:0] exp0, exp1;
                lba_t       exp_lba;
                sd_byte_t   exp_din;
                logic [3:0] exp_ack;
                logic       exp_hs, exp_vs, hs_prev;
                audio_t     smp;
                rst_n_i <= 1'b0;
                {pll_locked_i, reset_req_i, button_reset_i, download_i} <= 4'b1000;
                {joy_swap_i, joy0_i, joy1_i} <= '0;
                {sel_keypad_n_i, sel_joy_n_i} <= 4'b1111;
                {img_rd_i, img_wr_i, img_lba_i, img_din_i} <= '0;
                {host_ack_i, audio_i} <= '0;
                {hsync_n_i, vsync_n_i} <= 2'b11;
                repeat (10) @(posedge clk_sys);
                rst_n_i <= 1'b1;

                begin_test();
                wait_ce_fast(16);
                for (int k = 0; k < 64 && !timed_out; k++) begin
                        check_bit("ce_fast_o", ce_fast_o, (k % 4) == 0);
                        check_bit("ce_pix_o", ce_pix_o, (k % 8) == 0);
                        @(negedge clk_sys);
                end
                for (int r = 0; r < 16 && !timed_out; r++) begin
                        // Row bits are pll_locked, reset_req, button_reset, download
                        @(posedge clk_sys);
                        {pll_locked_i, reset_req_i, button_reset_i, download_i} <= r[3:0];
                        @(posedge clk_sys);
                        @(negedge clk_sys);
                        check_bit("core_rst_n_o", core_rst_n_o, r[3:0] == 4'b1000);
                        // No reads pending, so activity shows the download alone
                        check_bit("activity_o", activity_o, r[0]);
                end
                @(posedge clk_sys);
                {pll_locked_i, reset_req_i, button_reset_i, download_i} <= 4'b1000;
                if (!timed_out) wait_core_running(8);
                end_test("clock enables and reset");

                begin_test();
                @(posedge clk_sys);
                sel_keypad_n_i <= 2'b10;
                for (int r = 0; r < 8; r++) begin
                        @(posedge clk_sys);
                        joy0_i <= kp_table[r].joy;
                        @(negedge clk_sys);
                        check_code("ctrl_code0_o", ctrl_code0_o, kp_table[r].code);
                        check_bit("ctrl_fire_n_o[0]", ctrl_fire_n_o[0], kp_table[r].fire_n);
                        check_code("ctrl_code1_o", ctrl_code1_o, 4'b1111);
                end
                end_test("keypad mode");

                begin_test();
                for (int r = 0; r < 32; r++) begin
                        @(posedge clk_sys);
                        {joy_swap_i, sel_keypad_n_i, sel_joy_n_i} <= mode_table[r % 8];
                        joy0_i <= $random(seed);
                        joy1_i <= $random(seed);
                        @(negedge clk_sys);
                        exp0 = port_model(joy_swap_i ? joy1_i : joy0_i, sel_keypad_n_i[0],
                                          sel_joy_n_i[0]);
                        exp1 = port_model(joy_swap_i ? joy0_i : joy1_i, sel_keypad_n_i[1],
                                          sel_joy_n_i[1]);
                        check_code("ctrl_code0_o", ctrl_code0_o, exp0[4:1]);
                        check_bit("ctrl_fire_n_o[0]", ctrl_fire_n_o[0], exp0[0]);
                        check_code("ctrl_code1_o", ctrl_code1_o, exp1[4:1]);
                        check_bit("ctrl_fire_n_o[1]", ctrl_fire_n_o[1], exp1[0]);
                end
                end_test("joystick, both modes and swap");

                begin_test();
                exp_lba = '0;
                exp_din = '0;
                exp_ack = '0;
                for (int r = 0; r < 8; r++) begin
                        @(posedge clk_sys);
                        img_rd_i <= img_table[r].rd;
                        img_wr_i <= img_table[r].wr;
                        host_ack_i <= img_table[r].ack;
                        for (int i = 0; i < 4; i++) begin
                                img_lba_i[i] <= $random(seed);
                                img_din_i[i] <= $random(seed);
                        end
                        @(negedge clk_sys);
                        check_bit("activity_o", activity_o, |img_table[r].rd);
                        for (int i = 3; i >= 0; i--) begin
                                if (img_rd_i[i] | img_wr_i[i]) begin
                                        exp_ack[i] = host_ack_i;
                                end
                        end
                        // Highest index active requester owns the channel
                        for (int i = 0; i < 4; i++) begin
                                if (img_rd_i[i] | img_wr_i[i]) begin
                                        exp_lba = img_lba_i[i];
                                        exp_din = img_din_i[i];
                                end
                        end
                        @(negedge clk_sys);
                        check_lba("host_lba_o", host_lba_o, exp_lba);
                        check_byte("host_din_o", host_din_o, exp_din);
                        for (int i = 0; i < 4; i++) begin
                                check_bit($sformatf("img_ack_o[%0d]", i), img_ack_o[i],
                                          exp_ack[i]);
                        end
                end
                @(posedge clk_sys);
                img_rd_i <= '0;
                img_wr_i <= '0;
                end_test("image channel");

                begin_test();
                exp_hs = 1'b0;
                exp_vs = 1'b0;
                for (int r = 0; r < 12; r++) begin
                        @(posedge clk_sys);
                        {hsync_n_i, vsync_n_i} <= sync_table[r];
                        @(posedge clk_sys);
                        @(negedge clk_sys);
                        hs_prev = exp_hs;
                        exp_hs = ~sync_table[r][1];
                        if (!hs_prev && !sync_table[r][1]) exp_vs = ~sync_table[r][0];
                        check_bit("hs_o", hs_o, exp_hs);
                        check_bit("vs_o", vs_o, exp_vs);
                end
                for (int r = 0; r < 16; r++) begin
                        smp = $random(seed);
                        @(posedge clk_sys);
                        audio_i <= smp;
                        @(negedge clk_sys);
                        check_dac("dac_l_o", dac_l_o, {smp, smp[10:6]});
                        check_dac("dac_r_o", dac_r_o, {smp, smp[10:6]});
                end
                end_test("sync and audio");

                $display("Tests %0d, checks %0d, errors %0d", test_count, check_count,
                         error_count);
                if (error_count == 0 && !timed_out) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

// ==== verilog/adam_io_glue.sv ====
// IO glue around the console core, single clock domain clk_sys
// Image ports carry one packed word per drive, disks first then tapes
// Controller selects and results are active low
module adam_io_glue import adam_glue_pkg::*; #(
        parameter int NUM_DISKS  = 2,
        parameter int NUM_TAPES  = 2,
        localparam int NUM_IMAGES = NUM_DISKS + NUM_TAPES
) (
        input  logic                      clk_sys,
        input  logic                      rst_n_i,
        input  logic                      pll_locked_i,
        input  logic                      reset_req_i,
        input  logic                      button_reset_i,
        input  logic                      download_i,
        input  logic                      joy_swap_i,
        input  joy_t                      joy0_i,
        input  joy_t                      joy1_i,
        input  logic [1:0]                sel_keypad_n_i,
        input  logic [1:0]                sel_joy_n_i,
        input  logic [NUM_IMAGES-1:0]     img_rd_i,
        input  logic [NUM_IMAGES-1:0]     img_wr_i,
        input  lba_t [NUM_IMAGES-1:0]     img_lba_i,
        input  sd_byte_t [NUM_IMAGES-1:0] img_din_i,
        input  logic                      host_ack_i,
        input  logic                      hsync_n_i,
        input  logic                      vsync_n_i,
        input  audio_t                    audio_i,
        output logic                      ce_fast_o,
        output logic                      ce_pix_o,
        output logic                      core_rst_n_o,
        output cv_code_t                  ctrl_code0_o,
        output cv_code_t                  ctrl_code1_o,
        output logic [1:0]                ctrl_fire_n_o,
        output lba_t                      host_lba_o,
        output sd_byte_t                  host_din_o,
        output logic [NUM_IMAGES-1:0]     img_ack_o,
        output logic                      activity_o,
        output logic                      hs_o,
        output logic                      vs_o,
        output dac_t                      dac_l_o,
        output dac_t                      dac_r_o
);

        clock_reset_gen u_clock_reset_gen (
                .clk_sys        (clk_sys),
                .rst_n_i        (rst_n_i),
                .pll_locked_i   (pll_locked_i),
                .reset_req_i    (reset_req_i),
                .button_reset_i (button_reset_i),
                .download_i     (download_i),
                .ce_fast_o      (ce_fast_o),
                .ce_pix_o       (ce_pix_o),
                .core_rst_n_o   (core_rst_n_o)
        );

        controller_ports u_controller_ports (
                .joy_swap_i     (joy_swap_i),
                .joy0_i         (joy0_i),
                .joy1_i         (joy1_i),
                .sel_keypad_n_i (sel_keypad_n_i),
                .sel_joy_n_i    (sel_joy_n_i),
                .ctrl_code0_o   (ctrl_code0_o),
                .ctrl_code1_o   (ctrl_code1_o),
                .ctrl_fire_n_o  (ctrl_fire_n_o)
        );

        image_channel_mux #(
                .NUM_IMAGES (NUM_IMAGES)
        ) u_image_channel_mux (
                .clk_sys    (clk_sys),
                .rst_n_i    (rst_n_i),
                .img_rd_i   (img_rd_i),
                .img_wr_i   (img_wr_i),
                .img_lba_i  (img_lba_i),
                .img_din_i  (img_din_i),
                .host_ack_i (host_ack_i),
                .download_i (download_i),
                .host_lba_o (host_lba_o),
                .host_din_o (host_din_o),
                .img_ack_o  (img_ack_o),
                .activity_o (activity_o)
        );

        av_output_stage u_av_output_stage (
                .clk_sys   (clk_sys),
                .rst_n_i   (rst_n_i),
                .hsync_n_i (hsync_n_i),
                .vsync_n_i (vsync_n_i),
                .audio_i   (audio_i),
                .hs_o      (hs_o),
                .vs_o      (vs_o),
                .dac_l_o   (dac_l_o),
                .dac_r_o   (dac_r_o)
        );

endmodule

// ==== verilog/av_output_stage.sv ====
// Sync retiming and sound widening
// Vsync only updates while hsync is low on both sides of the register
module av_output_stage import adam_glue_pkg::*; (
        input  logic   clk_sys,
        input  logic   rst_n_i,
        input  logic   hsync_n_i,
        input  logic   vsync_n_i,
        input  audio_t audio_i,
        output logic   hs_o,
        output logic   vs_o,
        output dac_t   dac_l_o,
        output dac_t   dac_r_o
);

        localparam int pad_bits = $bits(dac_t) - $bits(audio_t);

        dac_t dac_word;

        always_ff @(posedge clk_sys) begin
                if (!rst_n_i) begin
                        hs_o <= 1'b0;
                        vs_o <= 1'b0;
                end else begin
                        hs_o <= ~hsync_n_i;
                        if (!hs_o && !hsync_n_i) begin
                                vs_o <= ~vsync_n_i;
                        end
                end
        end

        // Sample on top, its own MSBs repeated below to reach full scale
        assign dac_word = {audio_i, audio_i[$bits(audio_t)-1 -: pad_bits]};

        // Mono source, same word on both channels
        assign dac_l_o = dac_word;
        assign dac_r_o = dac_word;

endmodule

// ==== verilog/image_channel_mux.sv ====
// Shares the single disk-image host channel among the drive requesters
// Highest active index wins, outputs hold while nobody requests
// Requesters must keep rd and wr exclusive
module image_channel_mux import adam_glue_pkg::*; #(
        parameter int NUM_IMAGES = 4
) (
        input  logic                  clk_sys,
        input  logic                  rst_n_i,
        input  logic [NUM_IMAGES-1:0] img_rd_i,
        input  logic [NUM_IMAGES-1:0] img_wr_i,
        input  lba_t [NUM_IMAGES-1:0] img_lba_i,
        input  sd_byte_t [NUM_IMAGES-1:0] img_din_i,
        input  logic                  host_ack_i,
        input  logic                  download_i,
        output lba_t                  host_lba_o,
        output sd_byte_t              host_din_o,
        output logic [NUM_IMAGES-1:0] img_ack_o,
        output logic                  activity_o
);

        logic [NUM_IMAGES-1:0] active;

        assign active = img_rd_i | img_wr_i;

        // =====================================================================
        // Registered selection
        // =====================================================================
        always_ff @(posedge clk_sys) begin
                if (!rst_n_i) begin
                        host_lba_o <= '0;
                        host_din_o <= '0;
                        img_ack_o  <= '0;
                end else begin
                        // Ascending scan, so the last active index sticks
                        for (int i = 0; i < NUM_IMAGES; i++) begin
                                if (active[i]) begin
                                        host_lba_o   <= img_lba_i[i];
                                        host_din_o   <= img_din_i[i];
                                        img_ack_o[i] <= host_ack_i;
                                end
                        end
                end
        end

        // Activity LED, reads and cartridge download only
        assign activity_o = |img_rd_i | download_i;

        a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
                (img_rd_i & img_wr_i) == '0);

endmodule

// ==== verilog/controller_ports.sv ====
// Player swap and joystick to keypad remap for both controller ports
// Joystick bits 20 and up carry nothing and are ignored
module controller_ports import adam_glue_pkg::*; (
        input  logic        joy_swap_i,
        input  joy_t        joy0_i,
        input  joy_t        joy1_i,
        input  logic [1:0]  sel_keypad_n_i,
        input  logic [1:0]  sel_joy_n_i,
        output cv_code_t    ctrl_code0_o,
        output cv_code_t    ctrl_code1_o,
        output logic [1:0]  ctrl_fire_n_o
);

        joy_t    joy_a;
        joy_t    joy_b;
        keypad_t keypad0;
        keypad_t keypad1;

        ctrl_port_if port0 ();
        ctrl_port_if port1 ();

        // Host joystick word into keypad order
        function automatic keypad_t to_keypad(input joy_t joy);
                keypad_t kp;
                kp[9:0]           = joy[17:8];
                kp[kp_asterisk_c] = joy[6];
                kp[kp_number_c]   = joy[7];
                kp[kp_pt_c]       = joy[18];
                kp[kp_bt_c]       = joy[19];
                kp[kp_up_c]       = joy[3];
                kp[kp_down_c]     = joy[2];
                kp[kp_left_c]     = joy[1];
                kp[kp_right_c]    = joy[0];
                kp[kp_fire1_c]    = joy[4];
                kp[kp_fire2_c]    = joy[5];
                return kp;
        endfunction

        assign joy_a   = joy_swap_i ? joy1_i : joy0_i;
        assign joy_b   = joy_swap_i ? joy0_i : joy1_i;
        assign keypad0 = to_keypad(joy_a);
        assign keypad1 = to_keypad(joy_b);

        // Console side of both ports
        assign port0.sel_keypad_n = sel_keypad_n_i[0];
        assign port0.sel_joy_n    = sel_joy_n_i[0];
        assign port1.sel_keypad_n = sel_keypad_n_i[1];
        assign port1.sel_joy_n    = sel_joy_n_i[1];

        keypad_encoder u_pad0 (
                .buttons_i (keypad0),
                .port      (port0.pad)
        );

        keypad_encoder u_pad1 (
                .buttons_i (keypad1),
                .port      (port1.pad)
        );

        assign ctrl_code0_o  = port0.code;
        assign ctrl_code1_o  = port1.code;
        assign ctrl_fire_n_o = {port1.fire_n, port0.fire_n};

endmodule

// ==== verilog/keypad_encoder.sv ====
// Encodes one player's buttons onto the port, purely combinational
// Both selects low gives the AND of keypad and joystick results
module keypad_encoder import adam_glue_pkg::*; (
        input  keypad_t         buttons_i,
        ctrl_port_if.pad        port
);

        cv_code_t key_code;
        cv_code_t code_keypad;
        cv_code_t code_joy;
        logic     fire_keypad_n;
        logic     fire_joy_n;

        // =====================================================================
        // Keypad scan, lowest index wins
        // =====================================================================
        always_comb begin
                key_code = cv_key_none_c;
                for (int i = kp_bt_c; i >= 0; i--) begin
                        if (buttons_i[i]) begin
                                key_code = cv_key_table_c[i];
                        end
                end
        end

        always_comb begin
                code_keypad   = cv_key_none_c;
                fire_keypad_n = 1'b1;
                if (!port.sel_keypad_n) begin
                        code_keypad   = key_code;
                        // Keypad side reports fire 2
                        fire_keypad_n = ~buttons_i[kp_fire2_c];
                end
        end

        // =====================================================================
        // Joystick side
        // =====================================================================
        always_comb begin
                code_joy   = cv_key_none_c;
                fire_joy_n = 1'b1;
                if (!port.sel_joy_n) begin
                        code_joy   = ~{buttons_i[kp_up_c], buttons_i[kp_down_c],
                                       buttons_i[kp_left_c], buttons_i[kp_right_c]};
                        fire_joy_n = ~buttons_i[kp_fire1_c];
                end
        end

        assign port.code   = code_keypad & code_joy;
        assign port.fire_n = fire_keypad_n & fire_joy_n;

endmodule

// ==== verilog/clock_reset_gen.sv ====
// Clock enables from a free-running divider, first pulses one cycle after reset
// Core reset is one register stage behind its causes
module clock_reset_gen import adam_glue_pkg::*; (
        input  logic clk_sys,
        input  logic rst_n_i,
        input  logic pll_locked_i,
        input  logic reset_req_i,
        input  logic button_reset_i,
        input  logic download_i,
        output logic ce_fast_o,
        output logic ce_pix_o,
        output logic core_rst_n_o
);

        logic [CE_DIV_BITS-1:0] div;

        always_ff @(posedge clk_sys) begin
                if (!rst_n_i) begin
                        div          <= '0;
                        ce_fast_o    <= 1'b0;
                        ce_pix_o     <= 1'b0;
                        core_rst_n_o <= 1'b0;
                end else begin
                        div       <= div + 1'b1;
                        ce_fast_o <= (div[1:0] == 2'd0);
                        ce_pix_o  <= (div == '0);
                        // Any cause holds the core in reset
                        core_rst_n_o <= pll_locked_i & ~reset_req_i &
                                        ~button_reset_i & ~download_i;
                end
        end

        // Pixel enable is a subset of the fast enable
        a_pix_in_fast: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
                ce_pix_o |-> ce_fast_o);

endmodule

// ==== verilog/ctrl_port_if.sv ====
// One player's controller port
// Select levels come from the console, code and fire come back from the pad
// All four lines are active low
interface ctrl_port_if import adam_glue_pkg::*; ();

        logic     sel_keypad_n;
        logic     sel_joy_n;
        cv_code_t code;
        logic     fire_n;

        modport console (
                output sel_keypad_n,
                output sel_joy_n,
                input  code,
                input  fire_n
        );

        modport pad (
                input  sel_keypad_n,
                input  sel_joy_n,
                output code,
                output fire_n
        );

endinterface

// ==== verilog/adam_glue_pkg.sv ====
// Widths, vector types and controller key codes shared by the IO glue
// Key codes are active low, exactly as they appear on the port lines
package adam_glue_pkg;

        // Divider width, the fast enable looks at the low two bits only
        localparam int CE_DIV_BITS = 3;

        typedef logic [31:0] joy_t;
        typedef logic [19:0] keypad_t;
        typedef logic [3:0]  cv_code_t;
        typedef logic [31:0] lba_t;
        typedef logic [7:0]  sd_byte_t;
        typedef logic [10:0] audio_t;
        typedef logic [15:0] dac_t;

        // Keypad order, digits 0..9 sit at index 0..9
        localparam int kp_asterisk_c = 10;
        localparam int kp_number_c   = 11;
        localparam int kp_pt_c       = 12;
        localparam int kp_bt_c       = 13;
        localparam int kp_up_c       = 14;
        localparam int kp_down_c     = 15;
        localparam int kp_left_c     = 16;
        localparam int kp_right_c    = 17;
        localparam int kp_fire1_c    = 18;
        localparam int kp_fire2_c    = 19;

        localparam cv_code_t cv_key_0_c        = 4'b0011;
        localparam cv_code_t cv_key_1_c        = 4'b1110;
        localparam cv_code_t cv_key_2_c        = 4'b1101;
        localparam cv_code_t cv_key_3_c        = 4'b0110;
        localparam cv_code_t cv_key_4_c        = 4'b0001;
        localparam cv_code_t cv_key_5_c        = 4'b1001;
        localparam cv_code_t cv_key_6_c        = 4'b0111;
        localparam cv_code_t cv_key_7_c        = 4'b1100;
        localparam cv_code_t cv_key_8_c        = 4'b1000;
        localparam cv_code_t cv_key_9_c        = 4'b1011;
        localparam cv_code_t cv_key_asterisk_c = 4'b1010;
        localparam cv_code_t cv_key_number_c   = 4'b0101;
        localparam cv_code_t cv_key_pt_c       = 4'b0100;
        localparam cv_code_t cv_key_bt_c       = 4'b0010;
        localparam cv_code_t cv_key_none_c     = 4'b1111;

        // Code per keypad index 0..13
        localparam cv_code_t cv_key_table_c [0:kp_bt_c] = '{
                cv_key_0_c, cv_key_1_c, cv_key_2_c, cv_key_3_c, cv_key_4_c,
                cv_key_5_c, cv_key_6_c, cv_key_7_c, cv_key_8_c, cv_key_9_c,
                cv_key_asterisk_c, cv_key_number_c, cv_key_pt_c, cv_key_bt_c
        };

endpackage
